//--- Bender.yml
package:
  name: timer

export_include_dirs:
  - .

sources:
  - timer_pkg.sv
  - main_counter.sv
  - comparator_counter.sv
  - timer_regs.sv
  - timer_top.sv
  - target: test
    files:
      - tb_timer_top.sv

//--- all.f
+incdir+.
timer_pkg.sv
main_counter.sv
comparator_counter.sv
timer_regs.sv
timer_top.sv
tb_timer_top.sv

//--- comparator_counter.sv
`timescale 1ns/1ps

module comparator_counter
	import timer_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic [63:0] mtimer_count,
	input logic working,
	input cmp_write_t cmd,
	output cmp_conf_t conf,
	output logic [63:0] compare,
	output logic match_irq
);

	logic [63:0] period;
	logic match64;
	logic match32;
	logic hit;
	logic period_nz;

	assign match64 = (compare == mtimer_count);
	assign match32 = (compare[31:0] == mtimer_count[31:0]);
	assign hit = conf.mode64 ? match64 : match32;
	assign period_nz = conf.mode64 ? (period != 64'h0) : (period[31:0] != 32'h0);

	// A zero period never raises the interrupt.
	assign match_irq = conf.irqena && working && hit && period_nz;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Configuration, period and compare registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			conf <= '0;
			period <= 64'h0;
			compare <= 64'h0;
		end
		else begin
			if (cmd.conf_write) begin
				conf <= cmd.data.conf.cfg;
			end
			if (cmd.count_write) begin
				if (!cmd.dqm_n[0]) begin
					period[31:0] <= cmd.data.count[31:0];
					compare[31:0] <= cmd.data.count[31:0];
				end
				else begin
					compare[31:0] <= period[31:0];    // Masked half restarts from the period.
				end
				if (!cmd.dqm_n[1]) begin
					period[63:32] <= cmd.data.count[63:32];
					compare[63:32] <= cmd.data.count[63:32];
				end
				else begin
					compare[63:32] <= period[63:32];
				end
			end
			else if (conf.ena && conf.periodic && hit) begin
				compare <= compare + period;          // Next period boundary.
			end
		end
	end

	// Without a host load or a periodic reload the compare value holds.
	a_compare_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!cmd.count_write && !(conf.ena && conf.periodic) |=> $stable(compare));

endmodule

//--- main_counter.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module main_counter
	import timer_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input glb_conf_t glb,
	input logic count_write,
	input logic [1:0] dqm_n,
	input logic [63:0] data,
	output logic [63:0] mtimer_count,
	output logic working
);

	logic [`TIMER_PRESCALE_W-1:0] pre_cnt;
	logic tick;

	// Wrap also when prescale was lowered below the running count.
	assign tick = glb.run && (pre_cnt >= glb.prescale);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pre_cnt <= '0;
			mtimer_count <= 64'h0;
			working <= 1'b0;
		end
		else begin
			working <= glb.run;
			if (!glb.run || tick) begin
				pre_cnt <= '0;
			end
			else begin
				pre_cnt <= pre_cnt + 1'b1;
			end
			if (count_write) begin                 // Host load wins over the tick.
				if (!dqm_n[0]) begin
					mtimer_count[31:0] <= data[31:0];
				end
				if (!dqm_n[1]) begin
					mtimer_count[63:32] <= data[63:32];
				end
			end
			else if (tick) begin
				mtimer_count <= mtimer_count + 64'd1;
			end
		end
	end

	// Without a host load the timer only ever steps by one.
	a_count_step: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!count_write |=> (mtimer_count - $past(mtimer_count)) <= 64'd1);

endmodule

//--- tb_timer_top.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module tb_timer_top
	import timer_pkg::*;
();

	localparam int NUM = `TIMER_NUM_CMP;
	localparam int TIMEOUT = 200;

	logic iCLOCK;
	logic inRESET;
	logic req;
	bus_req_t bus_req;
	logic ack;
	logic [63:0] rdata;
	logic irq;

	int mismatches = 0;
	int timeouts = 0;
	int req_low = 0;
	logic [63:0] rng = 64'd96;
	logic [63:0] model_mtimer;
	logic [63:0] model_period [NUM];
	logic [63:0] model_compare [NUM];

	timer_top u_timer_top (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.req(req),
		.bus_req(bus_req),
		.ack(ack),
		.rdata(rdata),
		.irq(irq)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #4 iCLOCK = ~iCLOCK;
	end

	function automatic logic [63:0] rand64();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 7);
		rng = rng ^ (rng << 17);
		return rng;
	endfunction

	function automatic logic [`TIMER_ADDR_W-1:0] conf_addr(input int n);
		return `TIMER_ADDR_W'(4 + 2 * n);
	endfunction

	function automatic logic [`TIMER_ADDR_W-1:0] cmp_addr(input int n);
		return `TIMER_ADDR_W'(5 + 2 * n);
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			mismatches++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus access and handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic bus_access(input logic wr, input logic [`TIMER_ADDR_W-1:0] addr,
		input logic [1:0] dqm, input logic [63:0] wdata, output logic [63:0] rd);
		int t;
		int hold;
		@(posedge iCLOCK);
		bus_req.write <= wr;
		bus_req.addr <= addr;
		bus_req.dqm_n <= dqm;
		bus_req.data.count <= wdata;
		req <= 1'b1;
		t = 0;
		@(negedge iCLOCK);
		while (!ack && t < TIMEOUT) begin
			@(negedge iCLOCK);
			t++;
		end
		if (!ack) begin
			$display("ERROR: ack did not rise for address %0d", addr);
			timeouts++;
		end
		rd = rdata;
		hold = int'(rand64() % 3);
		repeat (hold) begin                              // Ack must hold while req is high.
			@(negedge iCLOCK);
			check("ack", 64'(ack), 64'h1);
		end
		@(posedge iCLOCK);
		req <= 1'b0;
		t = 0;
		@(negedge iCLOCK);
		while (ack && t < TIMEOUT) begin
			@(negedge iCLOCK);
			t++;
		end
		if (ack) begin
			$display("ERROR: ack did not fall for address %0d", addr);
			timeouts++;
		end
	endtask

	task automatic bus_write(input logic [`TIMER_ADDR_W-1:0] addr, input logic [1:0] dqm,
		input logic [63:0] wdata);
		logic [63:0] unused;
		bus_access(1'b1, addr, dqm, wdata, unused);
	endtask

	task automatic bus_read(input logic [`TIMER_ADDR_W-1:0] addr, output logic [63:0] rd);
		bus_access(1'b0, addr, 2'b00, 64'h0, rd);
	endtask

	task automatic read_and_check(input string name, input logic [`TIMER_ADDR_W-1:0] addr,
		input logic [63:0] exp);
		logic [63:0] rd;
		bus_read(addr, rd);
		check(name, rd, exp);
	endtask

	task automatic write_timer(input logic [1:0] dqm, input logic [63:0] v);
		bus_write(`TIMER_ADDR_W'(1), dqm, v);
		if (!dqm[0]) model_mtimer[31:0] = v[31:0];
		if (!dqm[1]) model_mtimer[63:32] = v[63:32];
	endtask

	// A masked compare half restarts from the old period half.
	task automatic write_compare(input int n, input logic [1:0] dqm, input logic [63:0] v);
		bus_write(cmp_addr(n), dqm, v);
		for (int h = 0; h < 2; h++) begin
			if (!dqm[h]) begin
				model_period[n][32*h +: 32] = v[32*h +: 32];
				model_compare[n][32*h +: 32] = v[32*h +: 32];
			end
			else begin
				model_compare[n][32*h +: 32] = model_period[n][32*h +: 32];
			end
		end
	endtask

	task automatic wait_for_irq();
		int t;
		t = 0;
		@(negedge iCLOCK);
		while (!irq && t < TIMEOUT) begin
			@(negedge iCLOCK);
			t++;
		end
		if (!irq) begin
			$display("ERROR: irq never rose");
			timeouts++;
		end
	endtask

	always @(negedge iCLOCK) begin
		req_low = req ? 0 : ((req_low < 2) ? req_low + 1 : 2);
		if (req_low >= 2) check("ack", 64'(ack), 64'h0);    // Req low for two cycles.
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int c;
		logic [63:0] v;
		logic [63:0] t;
		logic [63:0] k;
		req = 1'b0;
		bus_req = '0;
		inRESET = 1'b0;
		repeat (10) @(posedge iCLOCK);
		inRESET <= 1'b1;

		v = rand64();
		bus_write(0, 2'b00, v);
		read_and_check("glb", 0, v & 64'hFF01);        // Run in bit 0, prescale in 15:8.
		bus_write(0, 2'b00, 64'h0);
		for (int n = 0; n < NUM; n++) begin
			v = rand64() & 64'hF;
			bus_write(conf_addr(n), 2'b00, v);
			read_and_check("cmp_conf", conf_addr(n), v);
			write_compare(n, 2'b00, rand64());
			read_and_check("cmp_compare", cmp_addr(n), model_compare[n]);
		end
		for (int a = 3; a < 16; a++) begin
			if (a == 3 || a >= 4 + 2 * NUM) read_and_check("unmapped", `TIMER_ADDR_W'(a), 64'h0);
		end

		write_timer(2'b00, rand64());
		for (int i = 0; i < 6; i++) begin
			write_timer(2'(rand64()), rand64());
			read_and_check("mtimer", 1, model_mtimer);
			c = int'(rand64() % NUM);
			write_compare(c, 2'(rand64()), rand64());
			read_and_check("cmp_compare", cmp_addr(c), model_compare[c]);
		end
		for (int n = 0; n < NUM; n++) bus_write(conf_addr(n), 2'b00, 64'h0);
		bus_write(2, 2'b00, 64'hF);

		// One-shot match over all 64 bits.
		c = int'(rand64() % NUM);
		t = rand64() >> 1;
		k = 20 + rand64() % 41;
		write_timer(2'b00, t);
		write_compare(c, 2'b00, t + k);
		bus_write(conf_addr(c), 2'b00, 64'hE);
		bus_write(0, 2'b00, 64'h1);
		wait_for_irq();
		read_and_check("status", 2, 64'h1 << c);
		bus_write(2, 2'b00, 64'h1 << c);
		read_and_check("status", 2, 64'h0);
		check("irq", 64'(irq), 64'h0);
		repeat (40) @(negedge iCLOCK);
		read_and_check("status", 2, 64'h0);
		read_and_check("cmp_compare", cmp_addr(c), model_compare[c]);
		bus_write(0, 2'b00, 64'h0);
		bus_write(conf_addr(c), 2'b00, 64'h0);

		// Periodic mode reloads compare with compare plus period.
		c = (c + 1) % NUM;
		k = 20 + rand64() % 41;
		write_timer(2'b00, 64'h0);
		write_compare(c, 2'b00, k);
		bus_write(conf_addr(c), 2'b00, 64'hF);
		bus_write(0, 2'b00, 64'h1);
		wait_for_irq();
		read_and_check("cmp_compare", cmp_addr(c), model_compare[c] + model_period[c]);
		bus_write(2, 2'b00, 64'h1 << c);
		wait_for_irq();
		read_and_check("status", 2, 64'h1 << c);
		bus_write(conf_addr(c), 2'b00, 64'h0);
		bus_write(0, 2'b00, 64'h0);
		bus_write(2, 2'b00, 64'hF);

		// Low 32-bit match with a different high half.
		c = int'(rand64() % NUM);
		v = rand64();
		t = {v[63:32], 32'(rand64() % 1000)};
		k = 20 + rand64() % 41;
		write_timer(2'b00, t);
		write_compare(c, 2'b00, {~t[63:32], t[31:0] + k[31:0]});
		bus_write(conf_addr(c), 2'b00, 64'hC);
		bus_write(0, 2'b00, 64'h1);
		wait_for_irq();
		read_and_check("status", 2, 64'h1 << c);
		bus_write(0, 2'b00, 64'h0);
		bus_write(conf_addr(c), 2'b00, 64'h0);
		bus_write(2, 2'b00, 64'hF);

		// No interrupt without irqena or with a zero period.
		v = rand64();
		write_timer(2'b00, {v[63:32], 32'hFFFF_FFE0});
		write_compare(0, 2'b00, {v[31:0], 32'hFFFF_FFF0});
		bus_write(conf_addr(0), 2'b00, 64'h8);
		write_compare(1, 2'b00, 64'h0);
		bus_write(conf_addr(1), 2'b00, 64'hC);
		bus_write(0, 2'b00, 64'h1);
		repeat (80) @(negedge iCLOCK);
		check("irq", 64'(irq), 64'h0);
		read_and_check("status", 2, 64'h0);
		bus_write(0, 2'b00, 64'h0);

		$display("Errors: %0d check failures, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("Test OK");
		end
		else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- timer_pkg.sv
`include "timer_settings.svh"

package timer_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Comparator and global configuration
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic ena;                              // Comparator enable.
		logic irqena;                           // Interrupt enable.
		logic mode64;                           // Match over 64 bits, else low 32.
		logic periodic;                         // Reload compare by period on match.
	} cmp_conf_t;

	typedef struct packed {
		logic run;
		logic [`TIMER_PRESCALE_W-1:0] prescale;
	} glb_conf_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus write word and bus request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [59:0] pad;
		cmp_conf_t cfg;
	} conf_word_t;

	// One write word, seen as a count or as a comparator configuration.
	typedef union packed {
		logic [63:0] count;
		conf_word_t conf;
	} wr_data_u;

	typedef struct packed {
		logic write;
		logic [`TIMER_ADDR_W-1:0] addr;
		logic [1:0] dqm_n;                      // Active low, one bit per 32-bit half.
		wr_data_u data;
	} bus_req_t;

	// Per comparator write command, one cycle wide.
	typedef struct packed {
		logic conf_write;
		logic count_write;
		logic [1:0] dqm_n;
		wr_data_u data;
	} cmp_write_t;

endpackage

//--- timer_regs.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module timer_regs
	import timer_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic req,
	input bus_req_t bus_req,
	output logic ack,
	output logic [63:0] rdata,
	output logic irq,
	output glb_conf_t glb,
	output logic mt_write,
	output logic [1:0] mt_dqm_n,
	output logic [63:0] mt_data,
	input logic [63:0] mtimer_count,
	output cmp_write_t cmd [`TIMER_NUM_CMP],
	input cmp_conf_t cmp_conf [`TIMER_NUM_CMP],
	input logic [63:0] cmp_compare [`TIMER_NUM_CMP],
	input logic [`TIMER_NUM_CMP-1:0] match_irq
);

	localparam logic [`TIMER_ADDR_W-1:0] ADDR_GLB = `TIMER_ADDR_W'(0);
	localparam logic [`TIMER_ADDR_W-1:0] ADDR_MTIMER = `TIMER_ADDR_W'(1);
	localparam logic [`TIMER_ADDR_W-1:0] ADDR_STATUS = `TIMER_ADDR_W'(2);
	localparam int CMP_BASE = 4;

	logic access;
	logic wr_stb;
	logic [`TIMER_NUM_CMP-1:0] status;
	logic [`TIMER_NUM_CMP-1:0] clr;
	logic [63:0] rd_mux;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Four-phase handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign access = req && !ack;                  // High for exactly one cycle per request.
	assign wr_stb = access && bus_req.write;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ack <= 1'b0;
		end
		else if (access) begin
			ack <= 1'b1;
		end
		else if (!req) begin
			ack <= 1'b0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign mt_write = wr_stb && (bus_req.addr == ADDR_MTIMER);
	assign mt_dqm_n = bus_req.dqm_n;
	assign mt_data = bus_req.data.count;

	for (genvar n = 0; n < `TIMER_NUM_CMP; n++) begin : g_cmd
		assign cmd[n] = '{
			conf_write: wr_stb && (bus_req.addr == `TIMER_ADDR_W'(CMP_BASE + 2 * n)),
			count_write: wr_stb && (bus_req.addr == `TIMER_ADDR_W'(CMP_BASE + 2 * n + 1)),
			dqm_n: bus_req.dqm_n,
			data: bus_req.data
		};
	end

	// Global word keeps run in bit 0 and prescale in bits 15:8.
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			glb <= '0;
		end
		else if (wr_stb && (bus_req.addr == ADDR_GLB) && !bus_req.dqm_n[0]) begin
			glb.run <= bus_req.data.count[0];
			glb.prescale <= bus_req.data.count[8 +: `TIMER_PRESCALE_W];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sticky status and interrupt
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign clr = (wr_stb && (bus_req.addr == ADDR_STATUS) && !bus_req.dqm_n[0]) ?
		bus_req.data.count[`TIMER_NUM_CMP-1:0] : '0;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			status <= '0;
			irq <= 1'b0;
		end
		else begin
			status <= (status & ~clr) | match_irq;   // A new match beats the clear.
			irq <= |status;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Readback
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		rd_mux = 64'h0;                            // Unmapped addresses read zero.
		case (bus_req.addr)
			ADDR_GLB: rd_mux = {48'h0, glb.prescale, 7'h0, glb.run};
			ADDR_MTIMER: rd_mux = mtimer_count;
			ADDR_STATUS: rd_mux = 64'(status);
			default: begin
				for (int n = 0; n < `TIMER_NUM_CMP; n++) begin
					if (bus_req.addr == `TIMER_ADDR_W'(CMP_BASE + 2 * n)) begin
						rd_mux = {60'h0, cmp_conf[n]};
					end
					if (bus_req.addr == `TIMER_ADDR_W'(CMP_BASE + 2 * n + 1)) begin
						rd_mux = cmp_compare[n];
					end
				end
			end
		endcase
	end

	always_ff @(posedge iCLOCK) begin
		if (access) begin
			rdata <= rd_mux;                          // Held while ack is high.
		end
	end

	a_ack_after_req: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$rose(ack) |-> $past(req));

endmodule

//--- timer_settings.svh
`ifndef TIMER_SETTINGS_SVH
`define TIMER_SETTINGS_SVH

// Number of comparator counters behind the register block.
`define TIMER_NUM_CMP 4

// Register address width in 64-bit words.
`define TIMER_ADDR_W 4

// Width of the machine timer prescaler setting.
`define TIMER_PRESCALE_W 8

`endif

//--- timer_top.sv
`timescale 1ns/1ps
`include "timer_settings.svh"

module timer_top
	import timer_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic req,
	input bus_req_t bus_req,
	output logic ack,
	output logic [63:0] rdata,
	output logic irq
);

	glb_conf_t glb;
	logic mt_write;
	logic [1:0] mt_dqm_n;
	logic [63:0] mt_data;
	logic [63:0] mtimer_count;
	logic working;
	cmp_write_t cmd [`TIMER_NUM_CMP];
	cmp_conf_t cmp_conf [`TIMER_NUM_CMP];
	logic [63:0] cmp_compare [`TIMER_NUM_CMP];
	logic [`TIMER_NUM_CMP-1:0] match_irq;

	timer_regs u_regs (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.req(req),
		.bus_req(bus_req),
		.ack(ack),
		.rdata(rdata),
		.irq(irq),
		.glb(glb),
		.mt_write(mt_write),
		.mt_dqm_n(mt_dqm_n),
		.mt_data(mt_data),
		.mtimer_count(mtimer_count),
		.cmd(cmd),
		.cmp_conf(cmp_conf),
		.cmp_compare(cmp_compare),
		.match_irq(match_irq)
	);

	main_counter u_mtimer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.glb(glb),
		.count_write(mt_write),
		.dqm_n(mt_dqm_n),
		.data(mt_data),
		.mtimer_count(mtimer_count),
		.working(working)
	);

	for (genvar n = 0; n < `TIMER_NUM_CMP; n++) begin : g_cmp
		comparator_counter u_cmp (
			.iCLOCK(iCLOCK),
			.inRESET(inRESET),
			.mtimer_count(mtimer_count),
			.working(working),
			.cmd(cmd[n]),
			.conf(cmp_conf[n]),
			.compare(cmp_compare[n]),
			.match_irq(match_irq[n])
		);
	end

endmodule
